//--- common/calc_pkg.sv
`default_nettype none

package calc_pkg;

	//////////////////////////////
	// Widths and sizes
	//////////////////////////////
	localparam int word_width   = 16;
	localparam int addr_width   = 5;
	localparam int mem_depth    = 32;
	localparam int nibble_width = 4;
	localparam int line_width   = 128;

	// ASCII digits for the display
	localparam logic [7:0] char_zero = 8'h30;
	localparam logic [7:0] char_one  = 8'h31;

	//////////////////////////////
	// Encodings
	//////////////////////////////

	// Opcodes 3 and 4 have no operation
	typedef enum logic [2:0] {
		op_write     = 3'd0,
		op_read      = 3'd1,
		op_read_pair = 3'd2,
		op_max       = 3'd5,
		op_xor       = 3'd6,
		op_shift     = 3'd7
	} calc_op_e;

	typedef enum logic [1:0] {
		st_idle,
		st_collect,
		st_execute,
		st_show
	} seq_state_e;

	//////////////////////////////
	// Structs
	//////////////////////////////
	typedef struct packed {
		calc_op_e              op;
		logic [addr_width-1:0] rd_addr_a;
		logic [addr_width-1:0] rd_addr_b;
		logic [addr_width-1:0] wr_addr;
		logic [word_width-1:0] wr_data;
		logic [3:0]            shift;
	} calc_cmd_t;

	// Pair shows two words, otherwise address and one word
	typedef struct packed {
		logic                  pair;
		logic [addr_width-1:0] addr;
		logic [word_width-1:0] word_a;
		logic [word_width-1:0] word_b;
	} display_t;

endpackage

`default_nettype wire

//--- command/command_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module command_sequencer import calc_pkg::*; (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    rot,
	input  wire [nibble_width-1:0] bits,
	input  wire [word_width-1:0]   rd_data_a,
	input  wire [word_width-1:0]   rd_data_b,
	input  wire [word_width-1:0]   alu_result,
	output calc_cmd_t              cmd,
	output logic                   wr_en,
	output logic [word_width-1:0]  wr_word,
	output logic                   show,
	output display_t               display,
	output logic                   ready
);

	// Number of field nibbles following each opcode
	function automatic logic [3:0] field_total(input calc_op_e op);
		case (op)
			op_write:     field_total = 4'd6;
			op_read:      field_total = 4'd2;
			op_read_pair: field_total = 4'd4;
			op_shift:     field_total = 4'd5;
			default:      field_total = 4'd6;
		endcase
	endfunction

	// Slots in order a lo/hi, b lo/hi, w lo/hi, shift, data 0..3
	function automatic logic [3:0] field_slot(input calc_op_e op, input logic [3:0] idx);
		case (op)
			op_write: field_slot = (idx < 4'd2) ? idx + 4'd4 : idx + 4'd5;
			op_shift: field_slot = (idx < 4'd2) ? idx : idx + 4'd2;
			default:  field_slot = idx;
		endcase
	endfunction

	seq_state_e state;
	logic       prev_rot;
	logic       knob_edge;
	logic       op_valid;
	logic       writes_back;
	logic [3:0] field_idx;
	logic [3:0] slot;
	display_t   next_display;

	assign knob_edge   = rot && !prev_rot;
	assign op_valid    = (bits[2:0] != 3'd3) && (bits[2:0] != 3'd4);
	assign slot        = field_slot(cmd.op, field_idx);
	assign writes_back = !(cmd.op inside {op_read, op_read_pair});

	assign ready   = (state == st_idle);
	assign show    = (state == st_show);
	assign wr_en   = (state == st_execute) && writes_back;
	assign wr_word = (cmd.op == op_write) ? cmd.wr_data : alu_result;

	//////////////////////////////
	// Control FSM
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			// Knob held high through reset is not an edge
			prev_rot  <= 1'b1;
			state     <= st_idle;
			field_idx <= '0;
		end else begin
			prev_rot <= rot;
			case (state)
				st_idle: begin
					if (knob_edge && op_valid) begin
						state     <= st_collect;
						field_idx <= '0;
					end
				end
				st_collect: begin
					if (knob_edge) begin
						if (field_idx == field_total(cmd.op) - 4'd1) begin
							state     <= st_execute;
							field_idx <= '0;
						end else begin
							field_idx <= field_idx + 4'd1;
						end
					end
				end
				st_execute: state <= st_show;
				st_show:    state <= st_idle;
				default:    state <= st_idle;
			endcase
		end
	end

	//////////////////////////////
	// Command and display capture
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (state == st_idle && knob_edge && op_valid) begin
			cmd.op <= calc_op_e'(bits[2:0]);
		end
		if (state == st_collect && knob_edge) begin
			case (slot)
				4'd0:    cmd.rd_addr_a[3:0]            <= bits;
				4'd1:    cmd.rd_addr_a[addr_width-1]   <= bits[0];
				4'd2:    cmd.rd_addr_b[3:0]            <= bits;
				4'd3:    cmd.rd_addr_b[addr_width-1]   <= bits[0];
				4'd4:    cmd.wr_addr[3:0]              <= bits;
				4'd5:    cmd.wr_addr[addr_width-1]     <= bits[0];
				4'd6:    cmd.shift                     <= bits;
				4'd7:    cmd.wr_data[3:0]              <= bits;
				4'd8:    cmd.wr_data[7:4]              <= bits;
				4'd9:    cmd.wr_data[11:8]             <= bits;
				default: cmd.wr_data[15:12]            <= bits;
			endcase
		end
		if (state == st_execute) begin
			display <= next_display;
		end
	end

	// Reads show the read address, the rest show the written word
	always_comb begin
		next_display.pair   = (cmd.op == op_read_pair);
		next_display.word_b = rd_data_b;
		if (writes_back) begin
			next_display.addr   = cmd.wr_addr;
			next_display.word_a = wr_word;
		end else begin
			next_display.addr   = cmd.rd_addr_a;
			next_display.word_a = rd_data_a;
		end
	end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import calc_pkg::*; (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   wr_en,
	input  wire [addr_width-1:0]  wr_addr,
	input  wire [word_width-1:0]  wr_word,
	input  wire [addr_width-1:0]  rd_addr_a,
	input  wire [addr_width-1:0]  rd_addr_b,
	output logic [word_width-1:0] rd_data_a,
	output logic [word_width-1:0] rd_data_b
);

	logic [word_width-1:0] mem [mem_depth];

	// Whole file is cleared on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < mem_depth; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[wr_addr] <= wr_word;
		end
	end

	// Asynchronous read ports
	assign rd_data_a = mem[rd_addr_a];
	assign rd_data_b = mem[rd_addr_b];

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import calc_pkg::*; (
	input  wire calc_op_e         op,
	input  wire [word_width-1:0]  word_a,
	input  wire [word_width-1:0]  word_b,
	input  wire [3:0]             shift,
	output logic [word_width-1:0] result
);

	always_comb begin
		case (op)
			// Unsigned compare
			op_max: begin
				result = (word_a > word_b) ? word_a : word_b;
			end
			op_xor: begin
				result = word_a ^ word_b;
			end
			op_shift: begin
				result = word_a >> shift;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/lcd_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_formatter import calc_pkg::*; (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   show,
	input  wire display_t         display,
	output logic [line_width-1:0] line1,
	output logic [line_width-1:0] line2
);

	// One ASCII digit per bit, MSB in the top byte
	function automatic logic [line_width-1:0] to_ascii(input logic [word_width-1:0] value);
		logic [line_width-1:0] text;
		text = '0;
		for (int i = 0; i < word_width; i++) begin
			text[8*i +: 8] = value[i] ? char_one : char_zero;
		end
		return text;
	endfunction

	logic [word_width-1:0] addr_word;

	// Address is right aligned, padded with zeros
	assign addr_word = {{(word_width - addr_width){1'b0}}, display.addr};

	//////////////////////////////
	// Line registers
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			line1 <= '0;
			line2 <= '0;
		end else if (show) begin
			if (display.pair) begin
				line1 <= to_ascii(display.word_a);
				line2 <= to_ascii(display.word_b);
			end else begin
				line1 <= to_ascii(addr_word);
				line2 <= to_ascii(display.word_a);
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/knob_calc.sv
`timescale 1ns/1ps
`default_nettype none

module knob_calc import calc_pkg::*; (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    rot,
	input  wire [nibble_width-1:0] bits,
	output logic [line_width-1:0]  line1,
	output logic [line_width-1:0]  line2,
	output logic                   ready
);

	calc_cmd_t             cmd;
	logic [word_width-1:0] rd_data_a;
	logic [word_width-1:0] rd_data_b;
	logic [word_width-1:0] alu_result;
	logic [word_width-1:0] wr_word;
	logic                  wr_en;
	logic                  show;
	display_t              display;

	command_sequencer u_sequencer (
		.clk        (clk),
		.reset      (reset),
		.rot        (rot),
		.bits       (bits),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.alu_result (alu_result),
		.cmd        (cmd),
		.wr_en      (wr_en),
		.wr_word    (wr_word),
		.show       (show),
		.display    (display),
		.ready      (ready)
	);

	register_file u_register_file (
		.clk       (clk),
		.reset     (reset),
		.wr_en     (wr_en),
		.wr_addr   (cmd.wr_addr),
		.wr_word   (wr_word),
		.rd_addr_a (cmd.rd_addr_a),
		.rd_addr_b (cmd.rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	alu u_alu (
		.op     (cmd.op),
		.word_a (rd_data_a),
		.word_b (rd_data_b),
		.shift  (cmd.shift),
		.result (alu_result)
	);

	lcd_formatter u_lcd_formatter (
		.clk     (clk),
		.reset   (reset),
		.show    (show),
		.display (display),
		.line1   (line1),
		.line2   (line2)
	);

endmodule

`default_nettype wire

//--- test/calc_model.svh
`ifndef calc_model_svh
`define calc_model_svh

// Reference memory and the lines the display should hold
logic [word_width-1:0] model_mem [mem_depth];
logic [line_width-1:0] exp_line1;
logic [line_width-1:0] exp_line2;

// Characters are shifted in from the MSB down
function automatic logic [line_width-1:0] bit_string(input logic [word_width-1:0] value);
	logic [line_width-1:0] text;
	text = '0;
	for (int i = word_width - 1; i >= 0; i--) begin
		text = {text[line_width-9:0], value[i] ? char_one : char_zero};
	end
	return text;
endfunction

function automatic void model_reset();
	for (int i = 0; i < mem_depth; i++) begin
		model_mem[i] = '0;
	end
	exp_line1 = '0;
	exp_line2 = '0;
endfunction

// Result comes from memory as it was before the write
function automatic void model_apply(input calc_op_e op, input logic [addr_width-1:0] a,
		input logic [addr_width-1:0] b, input logic [addr_width-1:0] w,
		input logic [word_width-1:0] data, input logic [3:0] amount);
	logic [word_width-1:0] word_a;
	logic [word_width-1:0] word_b;
	logic [word_width-1:0] result;
	word_a = model_mem[a];
	word_b = model_mem[b];
	case (op)
		op_read: begin
			exp_line1 = bit_string({{(word_width - addr_width){1'b0}}, a});
			exp_line2 = bit_string(word_a);
		end
		op_read_pair: begin
			exp_line1 = bit_string(word_a);
			exp_line2 = bit_string(word_b);
		end
		default: begin
			if (op == op_write) begin
				result = data;
			end else if (op == op_max) begin
				result = (word_a >= word_b) ? word_a : word_b;
			end else if (op == op_xor) begin
				result = word_a ^ word_b;
			end else begin
				result = word_a >> amount;
			end
			model_mem[w] = result;
			exp_line1    = bit_string({{(word_width - addr_width){1'b0}}, w});
			exp_line2    = bit_string(result);
		end
	endcase
endfunction

`endif

//--- test/knob_calc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module knob_calc_tb import calc_pkg::*; ();

	logic                    clk = 1'b0;
	logic                    reset;
	logic                    rot;
	logic [nibble_width-1:0] bits;
	logic [line_width-1:0]   line1;
	logic [line_width-1:0]   line2;
	logic                    ready;

	logic [31:0] seed;
	int          checks;
	int          errors;
	int          test_base;
	event        timed_out;

	calc_op_e alu_ops [3] = '{op_max, op_xor, op_shift};
	calc_op_e all_ops [6] = '{op_write, op_read, op_read_pair, op_max, op_xor, op_shift};

	`include "calc_model.svh"

	knob_calc DUT (
		.clk   (clk),
		.reset (reset),
		.rot   (rot),
		.bits  (bits),
		.line1 (line1),
		.line2 (line2),
		.ready (ready)
	);

	always #50 clk = ~clk;

	//////////////////////////////
	// Random numbers
	//////////////////////////////
	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [addr_width-1:0] random_addr();
		logic [31:0] r;
		r = next_random();
		return r[31:27];
	endfunction

	function automatic logic [word_width-1:0] random_word();
		logic [31:0] r;
		r = next_random();
		return r[31:16];
	endfunction

	//////////////////////////////
	// Reporting
	//////////////////////////////
	task automatic end_test(input string name);
		$display("test %s: %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	task automatic report_and_finish();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	// Stops the run once a wait has timed out
	initial begin
		@(timed_out);
		report_and_finish();
	end

	//////////////////////////////
	// Knob stimulus
	//////////////////////////////
	task automatic turn_knob(input logic [nibble_width-1:0] value);
		@(posedge clk);
		bits <= value;
		rot  <= 1'b1;
		repeat (2) @(posedge clk);
		rot <= 1'b0;
	endtask

	// Upper bits of the second nibble are don't care
	task automatic send_addr(input logic [addr_width-1:0] addr);
		logic [31:0] r;
		r = next_random();
		turn_knob(addr[3:0]);
		turn_knob({r[31:29], addr[4]});
	endtask

	// Lines must hold their old value until ready returns
	task automatic wait_ready(input logic [line_width-1:0] old1,
			input logic [line_width-1:0] old2, output int latency);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (!ready) begin
				checks++;
				assert (line1 === old1 && line2 === old2) else begin
					errors++;
					$display("ERROR %0t: lines changed before ready", $time);
				end
			end
		end while (!ready && n < 20);
		if (!ready) begin
			errors++;
			$display("Timeout: ready stayed low for %0d clocks after the last knob turn", n);
			-> timed_out;
			forever @(posedge clk);
		end else begin
			latency = n + 1;
		end
	endtask

	task automatic run_command(input calc_op_e op, input logic [addr_width-1:0] a,
			input logic [addr_width-1:0] b, input logic [addr_width-1:0] w,
			input logic [word_width-1:0] data, input logic [3:0] amount);
		logic [line_width-1:0] old1;
		logic [line_width-1:0] old2;
		logic [31:0]           r;
		int                    latency;
		old1 = exp_line1;
		old2 = exp_line2;
		r    = next_random();
		turn_knob({r[31], op});
		case (op)
			op_write: begin
				send_addr(w);
				turn_knob(data[3:0]);
				turn_knob(data[7:4]);
				turn_knob(data[11:8]);
				turn_knob(data[15:12]);
			end
			op_read: send_addr(a);
			op_read_pair: begin
				send_addr(a);
				send_addr(b);
			end
			op_shift: begin
				send_addr(a);
				send_addr(w);
				turn_knob(amount);
			end
			default: begin
				send_addr(a);
				send_addr(b);
				send_addr(w);
			end
		endcase
		model_apply(op, a, b, w, data, amount);
		wait_ready(old1, old2, latency);
		checks++;
		assert (latency == 3) else begin
			errors++;
			$display("ERROR %0t: %s done after %0d clocks, expected 3", $time, op.name(), latency);
		end
		checks++;
		assert (line1 === exp_line1 && line2 === exp_line2) else begin
			errors++;
			$display("ERROR %0t: %s shows %s / %s, expected %s / %s", $time, op.name(),
				line1, line2, exp_line1, exp_line2);
		end
	endtask

	// Window covers a full execute and show
	task automatic run_ignored(input logic [2:0] code);
		logic [31:0] r;
		r = next_random();
		turn_knob({r[31], code});
		repeat (4) begin
			@(negedge clk);
			checks++;
			assert (ready && line1 === exp_line1 && line2 === exp_line2) else begin
				errors++;
				$display("ERROR %0t: opcode %0d was not ignored", $time, code);
			end
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial begin
		logic [addr_width-1:0] addr;
		logic [word_width-1:0] word;
		logic [31:0]           r;
		seed      = 32'hf2e9_77e4;
		checks    = 0;
		errors    = 0;
		test_base = 0;
		reset     = 1'b1;
		rot       = 1'b0;
		bits      = '0;
		model_reset();
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		@(negedge clk);
		checks++;
		assert (ready && line1 === '0 && line2 === '0) else begin
			errors++;
			$display("ERROR %0t: ready low or lines not cleared after reset", $time);
		end
		run_command(op_read, random_addr(), '0, '0, '0, '0);
		end_test("reset");

		for (int i = 0; i < 16; i++) begin
			addr = random_addr();
			run_command(op_write, '0, '0, addr, random_word(), '0);
			run_command(op_read, addr, '0, '0, '0, '0);
			run_command(op_read, random_addr(), '0, '0, '0, '0);
		end
		end_test("write_read");

		for (int i = 0; i < 8; i++) begin
			run_command(op_read_pair, random_addr(), random_addr(), '0, '0, '0);
		end
		end_test("read_pair");

		// Read back from the write address
		for (int i = 0; i < 12; i++) begin
			r    = next_random();
			addr = random_addr();
			word = random_word();
			run_command(alu_ops[int'(r[31:16]) % 3], random_addr(), random_addr(), addr,
				'0, word[3:0]);
			run_command(op_read, addr, '0, '0, '0, '0);
		end
		end_test("alu");

		run_ignored(3'd3);
		run_command(op_read, random_addr(), '0, '0, '0, '0);
		run_ignored(3'd4);
		addr = random_addr();
		run_command(op_write, '0, '0, addr, random_word(), '0);
		run_command(op_read, addr, '0, '0, '0, '0);
		end_test("ignored");

		for (int i = 0; i < 24; i++) begin
			r    = next_random();
			word = random_word();
			run_command(all_ops[int'(r[31:16]) % 6], random_addr(), random_addr(),
				random_addr(), word, word[3:0]);
		end
		end_test("random_mix");

		report_and_finish();
	end

endmodule

`default_nettype wire

//--- knob_calc.f
+incdir+test
common/calc_pkg.sv
command/command_sequencer.sv
verilog/register_file.sv
verilog/alu.sv
verilog/lcd_formatter.sv
verilog/knob_calc.sv
test/knob_calc_tb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator and run the knob_calc testbench
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f knob_calc.f --top-module knob_calc_tb \
	-o knob_calc_sim &&
./obj_dir/knob_calc_sim | tee /dev/stderr | grep -q "All checks passed" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
